// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_sprite_display
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
RUNFLAGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: player_motion.sv
// Player position and redraw sequencer
`timescale 1ns/1ns

module player_motion import tft_pkg::*; #(
    parameter int SPRITE_SIZE = 10,
    parameter int STEP        = 4
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   step,
    input  logic   btn_left,
    input  logic   btn_right,
    input  logic   btn_up,
    input  logic   btn_down,
    input  logic   drawer_busy,
    output logic   draw_start,
    output coord_t draw_x,
    output coord_t draw_y,
    output color_t draw_color,
    output coord_t player_x,
    output coord_t player_y,
    output logic   busy
);

    localparam int MAX_X = SCREEN_W - SPRITE_SIZE;
    localparam int MAX_Y = SCREEN_H - SPRITE_SIZE;
    localparam coord_t START_X = coord_t'(SCREEN_W / 2 - SPRITE_SIZE / 2);
    localparam coord_t START_Y = coord_t'(SCREEN_H / 2 - SPRITE_SIZE / 2);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ERASE,
        ST_ERASE_WAIT,
        ST_DRAW,
        ST_DRAW_WAIT
    } motion_state_t;

    motion_state_t state;
    coord_t        old_x, old_y;
    coord_t        next_x, next_y;
    logic          accept;

    assign busy   = (state != ST_IDLE) || drawer_busy;
    assign accept = step && !busy;

    // Opposite buttons cancel, and the result is clamped to the visible area.
    always_comb begin
        int nx;
        int ny;
        nx = int'(player_x);
        ny = int'(player_y);
        if (btn_left && !btn_right) nx = nx - STEP;
        if (btn_right && !btn_left) nx = nx + STEP;
        if (btn_up && !btn_down)    ny = ny - STEP;
        if (btn_down && !btn_up)    ny = ny + STEP;
        if (nx < 0) nx = 0;
        else if (nx > MAX_X) nx = MAX_X;
        if (ny < 0) ny = 0;
        else if (ny > MAX_Y) ny = MAX_Y;
        next_x = coord_t'(nx);
        next_y = coord_t'(ny);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_DRAW; // The start position is drawn once without an erase.
            draw_start <= 1'b0;
            player_x   <= START_X;
            player_y   <= START_Y;
        end else begin
            case (state)
                ST_IDLE: if (accept) begin
                    player_x <= next_x;
                    player_y <= next_y;
                    if (next_x != player_x || next_y != player_y) state <= ST_ERASE;
                end
                ST_ERASE: begin
                    draw_start <= 1'b1;
                    state      <= ST_ERASE_WAIT;
                end
                ST_ERASE_WAIT: begin
                    draw_start <= 1'b0;
                    // The drawer raises busy a cycle after the pulse, so wait past it.
                    if (!drawer_busy && !draw_start) state <= ST_DRAW;
                end
                ST_DRAW: begin
                    draw_start <= 1'b1;
                    state      <= ST_DRAW_WAIT;
                end
                ST_DRAW_WAIT: begin
                    draw_start <= 1'b0;
                    if (!drawer_busy && !draw_start) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && accept) begin
            old_x <= player_x;
            old_y <= player_y;
        end
        if (state == ST_ERASE) begin
            draw_x     <= old_x;
            draw_y     <= old_y;
            draw_color <= BACKGROUND_COLOR;
        end else if (state == ST_DRAW) begin
            draw_x     <= player_x;
            draw_y     <= player_y;
            draw_color <= PLAYER_COLOR;
        end
    end

endmodule

// File: sprite_display_properties.sv
// Display link assertions
`timescale 1ns/1ns

module sprite_display_properties #(
    parameter int CLK_DIV = 2
) (
    input logic clk,
    input logic rst,
    input logic draw_start,
    input logic drawer_busy,
    input logic tx_transmit,
    input logic tx_busy,
    input logic tft_cs
);

    int failures;
    int cs_low_cycles;

    always @(posedge clk) begin
        if (tft_cs) cs_low_cycles <= 0;
        else cs_low_cycles <= cs_low_cycles + 1;
    end

    transmit_when_idle: assert property (@(posedge clk) disable iff (rst)
        tx_transmit |-> !tx_busy)
        else begin
            failures++;
            $error("tx_transmit raised while the transmitter was busy");
        end

    start_when_idle: assert property (@(posedge clk) disable iff (rst)
        !(draw_start && drawer_busy))
        else begin
            failures++;
            $error("draw_start raised while the drawer was busy");
        end

    // One byte holds cs low for sixteen half periods of sclk.
    cs_whole_byte: assert property (@(posedge clk) disable iff (rst)
        $rose(tft_cs) |-> cs_low_cycles == 16 * CLK_DIV)
        else begin
            failures++;
            $error("tft_cs was low for %0d cycles", cs_low_cycles);
        end

endmodule

// File: sprite_display_top.sv
// Player sprite display subsystem
`timescale 1ns/1ns

module sprite_display_top import tft_pkg::*; #(
    parameter int SPRITE_SIZE = 10,
    parameter int STEP        = 4,
    parameter int CLK_DIV     = 2
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   step,
    input  logic   btn_left,
    input  logic   btn_right,
    input  logic   btn_up,
    input  logic   btn_down,
    output logic   tft_sclk,
    output logic   tft_mosi,
    output logic   tft_cs,
    output logic   tft_dc,
    output coord_t player_x,
    output coord_t player_y,
    output logic   busy
);

    logic      draw_start;
    coord_t    draw_x, draw_y;
    color_t    draw_color;
    logic      drawer_busy;
    logic      tx_transmit;
    logic      tx_dc;
    tft_byte_t tx_data;
    logic      tx_busy;

    player_motion #(
        .SPRITE_SIZE (SPRITE_SIZE),
        .STEP        (STEP)
    ) u_motion (
        .clk         (clk),
        .rst         (rst),
        .step        (step),
        .btn_left    (btn_left),
        .btn_right   (btn_right),
        .btn_up      (btn_up),
        .btn_down    (btn_down),
        .drawer_busy (drawer_busy),
        .draw_start  (draw_start),
        .draw_x      (draw_x),
        .draw_y      (draw_y),
        .draw_color  (draw_color),
        .player_x    (player_x),
        .player_y    (player_y),
        .busy        (busy)
    );

    sprite_drawer #(
        .SPRITE_SIZE (SPRITE_SIZE)
    ) u_drawer (
        .clk         (clk),
        .rst         (rst),
        .draw_start  (draw_start),
        .draw_x      (draw_x),
        .draw_y      (draw_y),
        .draw_color  (draw_color),
        .drawer_busy (drawer_busy),
        .tx_busy     (tx_busy),
        .tx_transmit (tx_transmit),
        .tx_dc       (tx_dc),
        .tx_data     (tx_data)
    );

    tft_spi_tx #(
        .CLK_DIV (CLK_DIV)
    ) u_tx (
        .clk         (clk),
        .rst         (rst),
        .tx_transmit (tx_transmit),
        .tx_dc       (tx_dc),
        .tx_data     (tx_data),
        .tx_busy     (tx_busy),
        .tft_sclk    (tft_sclk),
        .tft_mosi    (tft_mosi),
        .tft_cs      (tft_cs),
        .tft_dc      (tft_dc)
    );

endmodule

// File: sprite_drawer.sv
// Solid sprite command stream generator
`timescale 1ns/1ns

module sprite_drawer import tft_pkg::*; #(
    parameter int SPRITE_SIZE = 10
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      draw_start,
    input  coord_t    draw_x,
    input  coord_t    draw_y,
    input  color_t    draw_color,
    output logic      drawer_busy,
    input  logic      tx_busy,
    output logic      tx_transmit,
    output logic      tx_dc,
    output tft_byte_t tx_data
);

    localparam int PIX_W = $clog2(SPRITE_SIZE * SPRITE_SIZE + 1);
    localparam logic [PIX_W-1:0] LAST_PIX = PIX_W'(SPRITE_SIZE * SPRITE_SIZE - 1);
    localparam logic [3:0] SEL_PIXELS = 4'd11; // Header is done, pixels follow.

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_WAIT_HI,
        ST_WAIT_LO
    } drawer_state_t;

    drawer_state_t    state;
    logic [3:0]       sel_cnt;
    logic [PIX_W-1:0] pix_cnt;
    logic             byte_lo;
    coord_t           x_q, y_q;
    coord_t           x_end, y_end;
    color_t           color_q;
    logic             sel_dc;
    tft_byte_t        sel_data;
    logic             last_byte;

    assign drawer_busy = (state != ST_IDLE);
    assign x_end = x_q + coord_t'(SPRITE_SIZE - 1);
    assign y_end = y_q + coord_t'(SPRITE_SIZE - 1);
    assign last_byte = (sel_cnt == SEL_PIXELS) && byte_lo && (pix_cnt == LAST_PIX);

    always_comb begin
        sel_dc   = 1'b1;
        sel_data = byte_lo ? color_q[7:0] : color_q[15:8];
        case (sel_cnt)
            4'd0:  {sel_dc, sel_data} = {1'b0, CMD_CASET};
            4'd1:  sel_data = {7'b0, x_q[8]};
            4'd2:  sel_data = x_q[7:0];
            4'd3:  sel_data = {7'b0, x_end[8]};
            4'd4:  sel_data = x_end[7:0];
            4'd5:  {sel_dc, sel_data} = {1'b0, CMD_PASET};
            4'd6:  sel_data = {7'b0, y_q[8]};
            4'd7:  sel_data = y_q[7:0];
            4'd8:  sel_data = {7'b0, y_end[8]};
            4'd9:  sel_data = y_end[7:0];
            4'd10: {sel_dc, sel_data} = {1'b0, CMD_RAMWR};
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            tx_transmit <= 1'b0;
            sel_cnt     <= '0;
            pix_cnt     <= '0;
            byte_lo     <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: if (draw_start) begin
                    sel_cnt <= '0;
                    pix_cnt <= '0;
                    byte_lo <= 1'b0;
                    state   <= ST_SEND;
                end
                ST_SEND: if (!tx_busy) begin
                    tx_transmit <= 1'b1;
                    state       <= ST_WAIT_HI;
                end
                ST_WAIT_HI: begin
                    tx_transmit <= 1'b0;
                    if (tx_busy) state <= ST_WAIT_LO; // Byte was taken by the transmitter.
                end
                ST_WAIT_LO: if (!tx_busy) begin
                    if (last_byte) begin
                        state <= ST_IDLE;
                    end else begin
                        state <= ST_SEND;
                        if (sel_cnt != SEL_PIXELS) begin
                            sel_cnt <= sel_cnt + 4'd1;
                        end else if (byte_lo) begin
                            byte_lo <= 1'b0;
                            pix_cnt <= pix_cnt + PIX_W'(1);
                        end else begin
                            byte_lo <= 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && draw_start) begin
            x_q     <= draw_x;
            y_q     <= draw_y;
            color_q <= draw_color;
        end
        if (state == ST_SEND && !tx_busy) begin
            tx_dc   <= sel_dc;
            tx_data <= sel_data;
        end
    end

endmodule

// File: sprite_stimulus.txt
# left right up down strike_during_busy expected_x expected_y (x and y in hex)
# A strike line repeats its step while the redraw from the first step is running.
0 1 0 0 0 0c6 076
0 0 0 1 0 0c6 09e
0 1 1 0 0 0ee 076
0 1 1 0 0 116 04e
0 1 1 0 0 13c 026
0 1 1 0 0 13c 000
0 1 1 0 0 13c 000
1 1 0 0 0 13c 000
0 0 1 1 0 13c 000
1 0 0 0 1 114 000
1 0 0 1 0 0ec 028
1 0 0 0 0 0c4 028

// File: tb_sprite_display.sv
// Sprite display testbench
`timescale 1ns/1ns

module tb_sprite_display import tft_pkg::*; ();

    localparam int SPRITE_SIZE  = 4;
    localparam int STEP         = 40; // A wide step reaches the screen edges in a few lines.
    localparam int CLK_DIV      = 2;
    localparam int REDRAW_BYTES = 2 * (11 + 2 * SPRITE_SIZE * SPRITE_SIZE);
    localparam int MAX_TESTS    = 32;

    logic   clk;
    logic   rst;
    logic   step;
    logic   btn_left;
    logic   btn_right;
    logic   btn_up;
    logic   btn_down;
    logic   tft_sclk;
    logic   tft_mosi;
    logic   tft_cs;
    logic   tft_dc;
    logic   busy;
    coord_t player_x;
    coord_t player_y;

    logic [3:0] btns [MAX_TESTS]; // Left, right, up, down.
    logic       strike [MAX_TESTS];
    coord_t     want_x [MAX_TESTS];
    coord_t     want_y [MAX_TESTS];
    int         num_tests;
    logic       stimulus_loaded;
    int         errors;
    int         passed;
    int         failed;
    int         test_base;
    coord_t     cur_x;
    coord_t     cur_y;

    sprite_display_top #(
        .SPRITE_SIZE (SPRITE_SIZE),
        .STEP        (STEP),
        .CLK_DIV     (CLK_DIV)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .step      (step),
        .btn_left  (btn_left),
        .btn_right (btn_right),
        .btn_up    (btn_up),
        .btn_down  (btn_down),
        .tft_sclk  (tft_sclk),
        .tft_mosi  (tft_mosi),
        .tft_cs    (tft_cs),
        .tft_dc    (tft_dc),
        .player_x  (player_x),
        .player_y  (player_y),
        .busy      (busy)
    );

    tft_monitor #(
        .SPRITE_SIZE (SPRITE_SIZE)
    ) monitor (
        .clk      (clk),
        .rst      (rst),
        .tft_sclk (tft_sclk),
        .tft_mosi (tft_mosi),
        .tft_cs   (tft_cs),
        .tft_dc   (tft_dc),
        .player_x (player_x),
        .player_y (player_y)
    );

    bind sprite_display_top sprite_display_properties #(
        .CLK_DIV (CLK_DIV)
    ) props (
        .clk         (clk),
        .rst         (rst),
        .draw_start  (draw_start),
        .drawer_busy (drawer_busy),
        .tx_transmit (tx_transmit),
        .tx_busy     (tx_busy),
        .tft_cs      (tft_cs)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Each line may cost an erase and a draw, plus the draw after reset.
    initial begin
        wait (stimulus_loaded);
        #((num_tests + 1) * REDRAW_BYTES * 16 * CLK_DIV * 10 * 2);
        $display("watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

    function automatic int total_errors();
        return errors + monitor.errors + dut.props.failures;
    endfunction

    task automatic load_stimulus();
        int    fd;
        int    n;
        int    l, r, u, d, s;
        coord_t x, y;
        string line;
        fd = $fopen("sprite_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open sprite_stimulus.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && num_tests < MAX_TESTS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%d %d %d %d %d %h %h", l, r, u, d, s, x, y);
                if (n == 7) begin
                    btns[num_tests]   = {l[0], r[0], u[0], d[0]};
                    strike[num_tests] = s[0];
                    want_x[num_tests] = x;
                    want_y[num_tests] = y;
                    num_tests++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic press_step(input logic [3:0] b);
        @(posedge clk);
        {btn_left, btn_right, btn_up, btn_down} <= b;
        step <= 1'b1;
        @(posedge clk);
        step <= 1'b0;
    endtask

    task automatic wait_idle();
        @(posedge clk);
        while (busy) @(posedge clk);
    endtask

    task automatic close_test(input int num, input coord_t x, input coord_t y);
        monitor.compare_position(x, y);
        monitor.drain_expected();
        if (total_errors() == test_base) begin
            passed++;
            $display("test %0d passed at x=0x%03h y=0x%03h", num, x, y);
        end else begin
            failed++;
            $display("test %0d failed", num);
        end
        test_base = total_errors();
    endtask

    initial begin
        rst       = 1'b1;
        step      = 1'b0;
        btn_left  = 1'b0;
        btn_right = 1'b0;
        btn_up    = 1'b0;
        btn_down  = 1'b0;
        load_stimulus();
        stimulus_loaded = 1'b1;

        // The first redraw after reset is a lone draw at the start position.
        cur_x = coord_t'(SCREEN_W / 2 - SPRITE_SIZE / 2);
        cur_y = coord_t'(SCREEN_H / 2 - SPRITE_SIZE / 2);
        monitor.expect_draw(cur_x, cur_y, PLAYER_COLOR);
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        wait_idle();
        close_test(0, cur_x, cur_y);

        for (int t = 0; t < num_tests; t++) begin
            if (want_x[t] != cur_x || want_y[t] != cur_y) begin
                monitor.expect_draw(cur_x, cur_y, BACKGROUND_COLOR);
                monitor.expect_draw(want_x[t], want_y[t], PLAYER_COLOR);
            end
            press_step(btns[t]);
            if (strike[t]) begin
                repeat (20) @(posedge clk);
                if (!busy) begin
                    $display("busy was low when the second step of test %0d was given", t + 1);
                    errors++;
                end
                press_step(btns[t]); // Must be dropped.
            end
            wait_idle();
            close_test(t + 1, want_x[t], want_y[t]);
            cur_x = want_x[t];
            cur_y = want_y[t];
        end

        $display("%0d tests run, %0d passed, %0d failed", passed + failed, passed, failed);
        if (failed == 0 && total_errors() == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tft_monitor.sv
// Display link monitor
`timescale 1ns/1ns

module tft_monitor import tft_pkg::*; #(
    parameter int SPRITE_SIZE = 10
) (
    input logic   clk,
    input logic   rst,
    input logic   tft_sclk,
    input logic   tft_mosi,
    input logic   tft_cs,
    input logic   tft_dc,
    input coord_t player_x,
    input coord_t player_y
);

    logic [8:0] expected_q[$]; // Data/command flag sits above the byte.
    int         errors;
    int         byte_count;
    int         rises;
    tft_byte_t  shift;
    logic       dc_seen;
    logic       sclk_d;
    logic       cs_d;

    task automatic add_byte(input logic dc, input tft_byte_t data);
        expected_q.push_back({dc, data});
    endtask

    // Address window for the square, then every pixel high byte first.
    task automatic expect_draw(input coord_t x, input coord_t y, input color_t color);
        coord_t x_end;
        coord_t y_end;
        x_end = x + coord_t'(SPRITE_SIZE - 1);
        y_end = y + coord_t'(SPRITE_SIZE - 1);
        add_byte(1'b0, CMD_CASET);
        add_byte(1'b1, {7'b0, x[8]});
        add_byte(1'b1, x[7:0]);
        add_byte(1'b1, {7'b0, x_end[8]});
        add_byte(1'b1, x_end[7:0]);
        add_byte(1'b0, CMD_PASET);
        add_byte(1'b1, {7'b0, y[8]});
        add_byte(1'b1, y[7:0]);
        add_byte(1'b1, {7'b0, y_end[8]});
        add_byte(1'b1, y_end[7:0]);
        add_byte(1'b0, CMD_RAMWR);
        for (int i = 0; i < SPRITE_SIZE * SPRITE_SIZE; i++) begin
            add_byte(1'b1, color[15:8]);
            add_byte(1'b1, color[7:0]);
        end
    endtask

    task automatic compare_position(input coord_t x, input coord_t y);
        if (player_x !== x) begin
            $display("[FAIL] player_x: expected 0x%03h got 0x%03h", x, player_x);
            errors++;
        end
        if (player_y !== y) begin
            $display("[FAIL] player_y: expected 0x%03h got 0x%03h", y, player_y);
            errors++;
        end
    endtask

    // Bytes still queued once the DUT is idle were never sent.
    task automatic drain_expected();
        if (expected_q.size() != 0) begin
            $display("%0d expected link bytes never appeared", expected_q.size());
            errors++;
            expected_q.delete();
        end
    endtask

    task automatic check_byte(input tft_byte_t data, input logic dc, input int count);
        logic [8:0] want;
        if (count != 8) begin
            $display("chip select framed %0d sclk rises instead of 8 at byte %0d",
                     count, byte_count);
            errors++;
        end
        if (expected_q.size() == 0) begin
            $display("extra byte 0x%02h appeared on the link with no draw pending", data);
            errors++;
        end else begin
            want = expected_q.pop_front();
            if (data !== want[7:0]) begin
                $display("[FAIL] tft_mosi byte %0d: expected 0x%02h got 0x%02h",
                         byte_count, want[7:0], data);
                errors++;
            end
            if (dc !== want[8]) begin
                $display("[FAIL] tft_dc byte %0d: expected 0x%01h got 0x%01h",
                         byte_count, want[8], dc);
                errors++;
            end
        end
        byte_count++;
    endtask

    // Bits are taken on each rising sclk, and the byte closes when cs returns high.
    always @(posedge clk) begin
        sclk_d <= tft_sclk;
        cs_d   <= tft_cs;
        if (rst) begin
            rises <= 0;
        end else if (!tft_cs && tft_sclk && !sclk_d) begin
            shift   <= {shift[6:0], tft_mosi};
            dc_seen <= tft_dc;
            rises   <= rises + 1;
        end else if (tft_cs && !cs_d) begin
            check_byte(shift, dc_seen, rises);
            rises <= 0;
        end
    end

endmodule

// File: tft_pkg.sv
// TFT display link definitions
package tft_pkg;

    // Pixel coordinate, wide enough for the 320 pixel columns.
    typedef logic [8:0] coord_t;

    // One byte on the serial display link.
    typedef logic [7:0] tft_byte_t;

    // RGB565 pixel.
    typedef logic [15:0] color_t;

    localparam tft_byte_t CMD_CASET = 8'h2A; // Column address set.
    localparam tft_byte_t CMD_PASET = 8'h2B; // Page address set.
    localparam tft_byte_t CMD_RAMWR = 8'h2C; // Memory write.

    localparam color_t PLAYER_COLOR     = 16'h07E0; // Pure green.
    localparam color_t BACKGROUND_COLOR = 16'h0000;

    localparam int SCREEN_W = 320;
    localparam int SCREEN_H = 240;

endpackage

// File: tft_spi_tx.sv
// TFT serial byte transmitter
`timescale 1ns/1ns

module tft_spi_tx import tft_pkg::*; #(
    parameter int CLK_DIV = 2
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      tx_transmit,
    input  logic      tx_dc,
    input  tft_byte_t tx_data,
    output logic      tx_busy,
    output logic      tft_sclk,
    output logic      tft_mosi,
    output logic      tft_cs,
    output logic      tft_dc
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic [3:0]       half_cnt; // Sixteen half periods make one byte.
    tft_byte_t        shift_q;
    logic             dc_q;

    assign tft_mosi = shift_q[7];
    assign tft_dc   = dc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_busy  <= 1'b0;
            tft_cs   <= 1'b1;
            tft_sclk <= 1'b0;
            div_cnt  <= '0;
            half_cnt <= '0;
        end else if (!tx_busy) begin
            if (tx_transmit) begin
                tx_busy  <= 1'b1;
                tft_cs   <= 1'b0;
                div_cnt  <= '0;
                half_cnt <= '0;
            end
        end else if (div_cnt == DIV_W'(CLK_DIV - 1)) begin
            div_cnt <= '0;
            if (half_cnt == 4'd15) begin
                // The final falling edge ends the byte and releases the panel.
                tx_busy  <= 1'b0;
                tft_cs   <= 1'b1;
                tft_sclk <= 1'b0;
            end else begin
                half_cnt <= half_cnt + 4'd1;
                tft_sclk <= ~tft_sclk;
            end
        end else begin
            div_cnt <= div_cnt + DIV_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!tx_busy && tx_transmit) begin
            shift_q <= tx_data;
            dc_q    <= tx_dc;
        end else if (tx_busy && div_cnt == DIV_W'(CLK_DIV - 1)
                     && tft_sclk && half_cnt != 4'd15) begin
            shift_q <= {shift_q[6:0], 1'b0}; // Next bit goes out on the falling edge.
        end
    end

endmodule

// File: vlog.f
tft_pkg.sv
tft_spi_tx.sv
sprite_drawer.sv
player_motion.sv
sprite_display_top.sv
sprite_display_properties.sv
tft_monitor.sv
tb_sprite_display.sv
